/* all.f */
spaceInvPkg.sv
gameCfgIf.sv
objPosIf.sv
apbRegs.sv
vgaTiming.sv
gameFsm.sv
playerCtrl.sv
pixelMixer.sv
spaceInvTop.sv
tbSpaceInv.sv

/* apbRegs.sv */
// APB slave holding game control, tick and step registers plus game status
`timescale 1ns/1ps

module apbRegs (
	input  logic        clk,
	input  logic        reset,
	input  logic [7:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	gameCfgIf.cfgSource cfg,
	objPosIf.consumer   pos
);

	logic        access;
	logic        wrEn;
	logic        mapped;
	logic        enableReg;
	logic [15:0] tickReg;
	logic [3:0]  playerStepReg;
	logic [3:0]  bulletStepReg;
	logic [31:0] status;

	// Zero-wait slave
	assign pready = 1'b1;
	assign access = psel && penable;
	assign wrEn   = access && pwrite;

	assign mapped = (paddr == spaceInvPkg::REG_CTRL) || (paddr == spaceInvPkg::REG_TICK) ||
		(paddr == spaceInvPkg::REG_STEP) || (paddr == spaceInvPkg::REG_STATUS);

	// Status is read-only
	assign pslverr = access && (!mapped || (pwrite && paddr == spaceInvPkg::REG_STATUS));

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			enableReg     <= 1'b0;
			tickReg       <= spaceInvPkg::RESET_TICK;
			playerStepReg <= spaceInvPkg::RESET_PLAYER_STEP;
			bulletStepReg <= spaceInvPkg::RESET_BULLET_STEP;
		end
		else if (wrEn)
		begin
			case (paddr)
				spaceInvPkg::REG_CTRL: enableReg <= pwdata[0];
				spaceInvPkg::REG_TICK: tickReg <= pwdata[15:0];
				spaceInvPkg::REG_STEP:
				begin
					playerStepReg <= pwdata[3:0];
					bulletStepReg <= pwdata[11:8];
				end
				default: ;
			endcase
		end
	end

	assign cfg.enable     = enableReg;
	assign cfg.tickDiv    = tickReg;
	assign cfg.playerStep = playerStepReg;
	assign cfg.bulletStep = bulletStepReg;

	// State, bullet flag, bullet top, cannon left edge
	assign status = {6'd0, pos.playerLeft, 4'd0, pos.bulletTop, pos.bulletActive,
		pos.state == spaceInvPkg::stPlay};

	always_comb
	begin
		case (paddr)
			spaceInvPkg::REG_CTRL:   prdata = {31'd0, enableReg};
			spaceInvPkg::REG_TICK:   prdata = {16'd0, tickReg};
			spaceInvPkg::REG_STEP:   prdata = {20'd0, bulletStepReg, 4'd0, playerStepReg};
			spaceInvPkg::REG_STATUS: prdata = status;
			default:                 prdata = 32'd0;
		endcase
	end

	// Master must hold address and direction from setup into access
	assert property (@(posedge clk) disable iff (reset)
		(psel && !penable) |=> (!penable || ($stable(paddr) && $stable(pwrite))));

endmodule

/* gameCfgIf.sv */
// Game configuration from the register block to the game logic
`timescale 1ns/1ps

interface gameCfgIf;

	logic        enable;
	logic [15:0] tickDiv;
	logic [3:0]  playerStep;
	logic [3:0]  bulletStep;

	// Register block side
	modport cfgSource (
		output enable, tickDiv, playerStep, bulletStep
	);

	// Game logic side
	modport cfgSink (
		input enable, tickDiv, playerStep, bulletStep
	);

endinterface

/* gameFsm.sv */
// Title/play state machine with the periodic game tick
`timescale 1ns/1ps

module gameFsm (
	input  logic      clk,
	input  logic      reset,
	input  logic      start,
	gameCfgIf.cfgSink cfg,
	output logic      tick,
	output logic      gameStart,
	objPosIf.producer pos
);

	logic [15:0] tickCount;
	logic        inPlay;
	logic        goPlay;
	logic        tickDue;

	assign inPlay  = (pos.state == spaceInvPkg::stPlay);
	assign goPlay  = !inPlay && start && cfg.enable;
	// Compare with >= so a smaller divider written mid-run still wraps
	assign tickDue = (tickCount >= cfg.tickDiv);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pos.state <= spaceInvPkg::stTitle;
			tickCount <= '0;
			tick      <= 1'b0;
			gameStart <= 1'b0;
		end
		else
		begin
			if (goPlay)
				pos.state <= spaceInvPkg::stPlay;
			else if (inPlay && !cfg.enable)
				pos.state <= spaceInvPkg::stTitle;

			gameStart <= goPlay;
			// No tick on the way back to title
			tick      <= inPlay && cfg.enable && tickDue;

			if (!inPlay || tickDue)
				tickCount <= '0;
			else
				tickCount <= tickCount + 16'd1;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		tick |-> pos.state == spaceInvPkg::stPlay);

endmodule

/* objPosIf.sv */
// Object positions and game state toward the mixer and status register
`timescale 1ns/1ps

interface objPosIf;

	spaceInvPkg::gameStateT state;
	spaceInvPkg::coordT     playerLeft;
	spaceInvPkg::coordT     bulletLeft;
	spaceInvPkg::coordT     bulletTop;
	logic                   bulletActive;

	// State comes from the FSM, positions from the player logic
	modport producer (
		output state, playerLeft, bulletLeft, bulletTop, bulletActive
	);

	modport consumer (
		input state, playerLeft, bulletLeft, bulletTop, bulletActive
	);

endinterface

/* pixelMixer.sv */
// Object hit tests per pixel with registered RGB output
`timescale 1ns/1ps

module pixelMixer (
	input  logic               clk,
	input  logic               reset,
	input  logic               pixEn,
	input  spaceInvPkg::coordT hCount,
	input  spaceInvPkg::coordT vCount,
	objPosIf.consumer          pos,
	output logic [7:0]         r,
	output logic [7:0]         g,
	output logic [7:0]         b
);

	logic visible;
	logic inPlay;
	logic hitPlayer;
	logic hitBullet;
	logic hitBorder;

	assign visible = (hCount < spaceInvPkg::H_ACTIVE) && (vCount < spaceInvPkg::V_ACTIVE);
	assign inPlay  = (pos.state == spaceInvPkg::stPlay);

	assign hitPlayer = inPlay &&
		(hCount >= pos.playerLeft) && (hCount < pos.playerLeft + spaceInvPkg::PLAYER_W) &&
		(vCount >= spaceInvPkg::PLAYER_TOP) && (vCount <= spaceInvPkg::PLAYER_BOT);

	assign hitBullet = inPlay && pos.bulletActive &&
		(hCount >= pos.bulletLeft) && (hCount < pos.bulletLeft + spaceInvPkg::BULLET_W) &&
		(vCount >= pos.bulletTop) && (vCount < pos.bulletTop + spaceInvPkg::BULLET_H);

	// Border one column outside the cannon limits, drawn in every state
	assign hitBorder = (hCount == spaceInvPkg::FIELD_LEFT - 10'd1) ||
		(hCount == spaceInvPkg::FIELD_RIGHT + 10'd1);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			r <= 8'h00;
			g <= 8'h00;
			b <= 8'h00;
		end
		else if (pixEn)
		begin
			r <= 8'h00; // no red objects left in this game
			g <= (visible && hitPlayer) ? 8'hFF : 8'h00;
			b <= (visible && (hitBullet || hitBorder)) ? 8'hFF : 8'h00;
		end
	end

endmodule

/* playerCtrl.sv */
// Player cannon movement with field clamping and bullet launch and flight
`timescale 1ns/1ps

module playerCtrl (
	input  logic      clk,
	input  logic      reset,
	input  logic      left,
	input  logic      right,
	input  logic      shoot,
	input  logic      tick,
	input  logic      gameStart,
	gameCfgIf.cfgSink cfg,
	objPosIf.producer pos
);

	spaceInvPkg::coordT playerStep;
	spaceInvPkg::coordT bulletStep;
	spaceInvPkg::coordT rightLimit;
	spaceInvPkg::coordT leftNext;
	spaceInvPkg::coordT rightNext;
	logic               launch;

	assign playerStep = {6'd0, cfg.playerStep};
	assign bulletStep = {6'd0, cfg.bulletStep};

	// Largest left edge that keeps the cannon inside the field
	assign rightLimit = spaceInvPkg::FIELD_RIGHT - spaceInvPkg::PLAYER_W;

	assign leftNext = (pos.playerLeft < spaceInvPkg::FIELD_LEFT + playerStep) ?
		spaceInvPkg::FIELD_LEFT : pos.playerLeft - playerStep;
	assign rightNext = (pos.playerLeft + playerStep > rightLimit) ?
		rightLimit : pos.playerLeft + playerStep;

	assign launch = (pos.state == spaceInvPkg::stPlay) && shoot && !pos.bulletActive;

	// Cannon
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			pos.playerLeft <= spaceInvPkg::PLAYER_START_X;
		else if (gameStart)
			pos.playerLeft <= spaceInvPkg::PLAYER_START_X;
		else if (tick && left && !right)
			pos.playerLeft <= leftNext;
		else if (tick && right && !left)
			pos.playerLeft <= rightNext;
	end

	// Bullet, one in flight at a time
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pos.bulletActive <= 1'b0;
			pos.bulletLeft   <= '0;
			pos.bulletTop    <= '0;
		end
		else if (gameStart)
			pos.bulletActive <= 1'b0;
		else if (launch)
		begin
			pos.bulletActive <= 1'b1;
			pos.bulletLeft   <= pos.playerLeft + spaceInvPkg::BULLET_OFFSET;
			pos.bulletTop    <= spaceInvPkg::BULLET_START_Y;
		end
		else if (tick && pos.bulletActive)
		begin
			if (pos.bulletTop >= bulletStep)
				pos.bulletTop <= pos.bulletTop - bulletStep;
			else
				pos.bulletActive <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		(pos.playerLeft >= spaceInvPkg::FIELD_LEFT) &&
		(pos.playerLeft + spaceInvPkg::PLAYER_W <= spaceInvPkg::FIELD_RIGHT));

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass or fail decided from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tbSpaceInv \
	--Mdir obj_dir -o simSpaceInv > build.log 2>&1 \
	&& ./obj_dir/simSpaceInv > sim.log 2>&1 ; \
	grep -qx "Simulation completed successfully" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL, see build.log and sim.log"; exit 1; }

/* spaceInvPkg.sv */
// Shared constants and types for the space invaders video game core
package spaceInvPkg;

	// Screen coordinate, wide enough for a full 800 pixel line
	typedef logic [9:0] coordT;

	typedef enum logic {
		stTitle = 1'b0,
		stPlay  = 1'b1
	} gameStateT;

	// Horizontal timing in pixels
	localparam logic [9:0] H_ACTIVE = 10'd640;
	localparam logic [9:0] H_FP     = 10'd16;
	localparam logic [9:0] H_SYNC   = 10'd96;
	localparam logic [9:0] H_BP     = 10'd48;
	localparam logic [9:0] H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;

	// Vertical timing in lines
	localparam logic [9:0] V_ACTIVE = 10'd480;
	localparam logic [9:0] V_FP     = 10'd11;
	localparam logic [9:0] V_SYNC   = 10'd2;
	localparam logic [9:0] V_BP     = 10'd32;
	localparam logic [9:0] V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;

	// Inclusive cannon limits, border sits one column outside each
	localparam coordT FIELD_LEFT  = 10'd100;
	localparam coordT FIELD_RIGHT = 10'd540;

	// Player cannon sprite
	localparam coordT PLAYER_W       = 10'd40;
	localparam coordT PLAYER_TOP     = 10'd410;
	localparam coordT PLAYER_BOT     = 10'd440;
	localparam coordT PLAYER_START_X = 10'd300;

	// Player bullet sprite
	localparam coordT BULLET_OFFSET  = 10'd20;
	localparam coordT BULLET_W       = 10'd2;
	localparam coordT BULLET_H       = 10'd10;
	localparam coordT BULLET_START_Y = 10'd400;

	// APB register map
	localparam logic [7:0] REG_CTRL   = 8'h00;
	localparam logic [7:0] REG_TICK   = 8'h04;
	localparam logic [7:0] REG_STEP   = 8'h08;
	localparam logic [7:0] REG_STATUS = 8'h0C;

	// Register reset values
	localparam logic [15:0] RESET_TICK        = 16'd1000;
	localparam logic [3:0]  RESET_PLAYER_STEP = 4'd10;
	localparam logic [3:0]  RESET_BULLET_STEP = 4'd10;

endpackage

/* spaceInvTop.sv */
// Space invaders core top level with APB configuration and VGA output
`timescale 1ns/1ps

module spaceInvTop (
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  logic        left,
	input  logic        right,
	input  logic        shoot,
	input  logic [7:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        vgaClk,
	output logic        hsync,
	output logic        vsync,
	output logic        syncB,
	output logic        blankB,
	output logic [7:0]  r,
	output logic [7:0]  g,
	output logic [7:0]  b
);

	logic               pixEn;
	logic               tick;
	logic               gameStart;
	spaceInvPkg::coordT hCount;
	spaceInvPkg::coordT vCount;

	gameCfgIf cfgBus ();
	objPosIf  posBus ();

	// Pixel enable doubles as the DAC clock, composite sync unused
	assign vgaClk = pixEn;
	assign syncB  = 1'b0;

	apbRegs regs (
		.clk(clk), .reset(reset),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.cfg(cfgBus.cfgSource), .pos(posBus.consumer)
	);

	gameFsm fsm (
		.clk(clk), .reset(reset), .start(start), .cfg(cfgBus.cfgSink),
		.tick(tick), .gameStart(gameStart), .pos(posBus.producer)
	);

	playerCtrl player (
		.clk(clk), .reset(reset), .left(left), .right(right), .shoot(shoot),
		.tick(tick), .gameStart(gameStart), .cfg(cfgBus.cfgSink), .pos(posBus.producer)
	);

	vgaTiming timing (
		.clk(clk), .reset(reset), .pixEn(pixEn), .hsync(hsync), .vsync(vsync),
		.blankB(blankB), .hCount(hCount), .vCount(vCount)
	);

	pixelMixer mixer (
		.clk(clk), .reset(reset), .pixEn(pixEn), .hCount(hCount), .vCount(vCount),
		.pos(posBus.consumer), .r(r), .g(g), .b(b)
	);

endmodule

/* tbSpaceInv.sv */
// Testbench for the space invaders core covering APB, game play and VGA timing
`timescale 1ns/1ps

module tbSpaceInv;

	localparam int TICK_DIV     = 3;
	localparam int NUM_ROWS     = 12;
	localparam int LINE_CYCLES  = 2 * int'(spaceInvPkg::H_TOTAL);
	localparam int FRAME_CYCLES = LINE_CYCLES * int'(spaceInvPkg::V_TOTAL);

	typedef struct {
		logic lft;
		logic rgt;
		logic sht;
		int   ticks;
		int   expLeft;
		logic expActive;
		int   expTop;
		int   expBulletLeft;
	} rowT;

	logic        clk;
	logic        reset;
	logic        start;
	logic        left;
	logic        right;
	logic        shoot;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        vgaClk;
	logic        hsync;
	logic        vsync;
	logic        syncB;
	logic        blankB;
	logic [7:0]  r;
	logic [7:0]  g;
	logic [7:0]  b;

	rowT stim [NUM_ROWS];
	int  errorCount = 0;
	int  checkCount = 0;
	int  cycleCount = 0;
	int  cycleLimit = 0;

	spaceInvTop UUT (
		.clk(clk), .reset(reset), .start(start), .left(left), .right(right), .shoot(shoot),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.vgaClk(vgaClk), .hsync(hsync), .vsync(vsync), .syncB(syncB), .blankB(blankB),
		.r(r), .g(g), .b(b)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Watchdog
	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout: run did not finish within %0d clock cycles", cycleLimit);
			$display("Checks: %0d, errors: %0d", checkCount, errorCount);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		assert (actual === expected)
		else
		begin
			errorCount++;
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
		@(negedge clk);
		paddr   = addr;
		pwdata  = data;
		pwrite  = 1'b1;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		#2;
		err = pslverr;
		checkValue("pready", 32'(pready), 32'd1);
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(negedge clk);
		paddr   = addr;
		pwrite  = 1'b0;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		#2;
		data = prdata;
		err  = pslverr;
		checkValue("pready", 32'(pready), 32'd1);
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic writeExpect(input logic [7:0] addr, input logic [31:0] data,
		input logic expErr, input string name);
		logic err;
		apbWrite(addr, data, err);
		checkValue({name, " pslverr"}, 32'(err), 32'(expErr));
	endtask

	task automatic readExpect(input logic [7:0] addr, input logic [31:0] expData,
		input logic expErr, input string name);
		logic [31:0] data;
		logic        err;
		apbRead(addr, data, err);
		checkValue(name, data, expData);
		checkValue({name, " pslverr"}, 32'(err), 32'(expErr));
	endtask

	// Status layout: bit 0 play, bit 1 bullet, 11:2 bullet top, 25:16 cannon left
	task automatic checkStatus(input logic expPlay, input logic expActive, input int expTop,
		input int expLeft, input string tag);
		logic [31:0] data;
		logic        err;
		apbRead(spaceInvPkg::REG_STATUS, data, err);
		checkValue({tag, " pslverr"}, 32'(err), 32'd0);
		checkValue({tag, " state"}, 32'(data[0]), 32'(expPlay));
		checkValue({tag, " bulletActive"}, 32'(data[1]), 32'(expActive));
		checkValue({tag, " bulletTop"}, 32'(data[11:2]), expTop);
		checkValue({tag, " playerLeft"}, 32'(data[25:16]), expLeft);
	endtask

	task automatic pulseStart();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	// Player step 12, bullet step 15, cannon starts at 300
	task automatic loadTable();
		stim[0]  = '{1'b0, 1'b1, 1'b0, 5, 360, 1'b0, 0, 0};
		stim[1]  = '{1'b0, 1'b1, 1'b0, 15, 500, 1'b0, 0, 0};
		stim[2]  = '{1'b1, 1'b1, 1'b0, 3, 500, 1'b0, 0, 0};
		stim[3]  = '{1'b0, 1'b0, 1'b0, 2, 500, 1'b0, 0, 0};
		stim[4]  = '{1'b1, 1'b0, 1'b0, 4, 452, 1'b0, 0, 0};
		stim[5]  = '{1'b0, 1'b0, 1'b1, 0, 452, 1'b1, 400, 472};
		stim[6]  = '{1'b1, 1'b0, 1'b0, 2, 428, 1'b1, 370, 472};
		stim[7]  = '{1'b0, 1'b0, 1'b1, 1, 428, 1'b1, 355, 472};
		stim[8]  = '{1'b0, 1'b0, 1'b0, 23, 428, 1'b1, 10, 472};
		stim[9]  = '{1'b0, 1'b0, 1'b0, 1, 428, 1'b0, 10, 472};
		stim[10] = '{1'b1, 1'b0, 1'b0, 34, 100, 1'b0, 10, 472};
		stim[11] = '{1'b0, 1'b0, 1'b1, 0, 100, 1'b1, 400, 120};
	endtask

	// Entered on a falling edge with a tick pending, status read ends before the next one
	task automatic applyRow(input int idx);
		rowT row;
		row   = stim[idx];
		left  = row.lft;
		right = row.rgt;
		shoot = row.sht;
		if (row.ticks == 0)
			@(negedge clk);
		for (int k = 0; k < row.ticks; k++)
		begin
			while (!UUT.tick)
				@(negedge clk);
			@(negedge clk);
		end
		left  = 1'b0;
		right = 1'b0;
		shoot = 1'b0;
		checkStatus(1'b1, row.expActive, row.expTop, row.expLeft, $sformatf("row %0d", idx));
		checkValue($sformatf("row %0d bulletLeft", idx), 32'(UUT.posBus.bulletLeft),
			row.expBulletLeft);
	endtask

	task automatic scanLine(input logic [9:0] line, output int greenCount, output int blueCount,
		output int redCount);
		greenCount = 0;
		blueCount  = 0;
		redCount   = 0;
		while (UUT.vCount == line)
			@(negedge clk);
		while (UUT.vCount != line)
			@(negedge clk);
		while (UUT.vCount == line)
		begin
			if (g == 8'hFF)
				greenCount++;
			if (b == 8'hFF)
				blueCount++;
			if (r != 8'h00)
				redCount++;
			@(negedge clk);
		end
	endtask

	// One full line from hsync falling edge to the next, on active line 100
	task automatic measureLine();
		int   pixels;
		int   syncPixels;
		int   activePixels;
		logic prevSync;
		pixels       = 0;
		syncPixels   = 0;
		activePixels = 0;
		while (UUT.vCount != 10'd100)
			@(negedge clk);
		while (hsync !== 1'b1)
			@(negedge clk);
		while (hsync !== 1'b0)
			@(negedge clk);
		do
		begin
			if (vgaClk)
			begin
				pixels++;
				if (!hsync)
					syncPixels++;
				if (blankB)
					activePixels++;
			end
			prevSync = hsync;
			@(negedge clk);
		end while (!(prevSync && !hsync));
		checkValue("pixel enables per line", pixels, 800);
		checkValue("hsync low pixel enables", syncPixels, 96);
		checkValue("blankB high pixel enables", activePixels, 640);
	endtask

	// Two sync lines of 800 pixels, two clocks per pixel
	task automatic measureVsync();
		int lowClocks;
		lowClocks = 0;
		while (vsync !== 1'b1)
			@(negedge clk);
		while (vsync !== 1'b0)
			@(negedge clk);
		while (vsync === 1'b0)
		begin
			lowClocks++;
			@(negedge clk);
		end
		checkValue("vsync low clocks", lowClocks, 3200);
	endtask

	initial
	begin
		int greenCount;
		int blueCount;
		int redCount;
		int totalTicks;
		reset   = 1'b1;
		start   = 1'b0;
		left    = 1'b0;
		right   = 1'b0;
		shoot   = 1'b0;
		paddr   = 8'h00;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = 32'd0;

		loadTable();
		totalTicks = 0;
		for (int i = 0; i < NUM_ROWS; i++)
			totalTicks += stim[i].ticks;
		// Two frames for the line 420 scans plus lead-in and vsync lines, ticks and APB traffic
		cycleLimit = 2 * FRAME_CYCLES + 256 * LINE_CYCLES + totalTicks * (TICK_DIV + 1) +
			NUM_ROWS * 16 + 2000;

		repeat (4) @(posedge clk);
		@(negedge clk);
		checkValue("hsync in reset", 32'(hsync), 32'd1);
		checkValue("vsync in reset", 32'(vsync), 32'd1);
		checkValue("blankB in reset", 32'(blankB), 32'd0);
		checkValue("rgb in reset", {8'd0, r, g, b}, 32'd0);
		checkValue("pslverr in reset", 32'(pslverr), 32'd0);
		reset = 1'b0;

		measureLine();
		checkValue("syncB", 32'(syncB), 32'd0);

		// Register reset values, readback and error responses
		readExpect(spaceInvPkg::REG_CTRL, 32'd0, 1'b0, "CTRL");
		readExpect(spaceInvPkg::REG_TICK, 32'd1000, 1'b0, "TICK");
		readExpect(spaceInvPkg::REG_STEP, 32'h0A0A, 1'b0, "STEP");
		checkStatus(1'b0, 1'b0, 0, 300, "reset status");
		writeExpect(spaceInvPkg::REG_TICK, TICK_DIV, 1'b0, "TICK write");
		readExpect(spaceInvPkg::REG_TICK, TICK_DIV, 1'b0, "TICK readback");
		writeExpect(spaceInvPkg::REG_STEP, 32'h0F0C, 1'b0, "STEP write");
		readExpect(spaceInvPkg::REG_STEP, 32'h0F0C, 1'b0, "STEP readback");
		writeExpect(8'h10, 32'h1, 1'b1, "unmapped write");
		readExpect(8'h10, 32'd0, 1'b1, "unmapped read");
		writeExpect(spaceInvPkg::REG_STATUS, 32'h1, 1'b1, "STATUS write");

		// Start only counts with the game enabled
		pulseStart();
		checkStatus(1'b0, 1'b0, 0, 300, "start while disabled");
		writeExpect(spaceInvPkg::REG_CTRL, 32'h1, 1'b0, "CTRL write");
		pulseStart();
		checkStatus(1'b1, 1'b0, 0, 300, "start while enabled");

		while (!UUT.tick)
			@(negedge clk);
		for (int i = 0; i < NUM_ROWS; i++)
			applyRow(i);

		// Cannon 40 pixels wide, each pixel held for two clocks
		scanLine(10'd420, greenCount, blueCount, redCount);
		checkValue("green clocks on line 420 in play", greenCount, 80);
		// Only the border columns 99 and 541, the bullet is far above this line
		checkValue("blue clocks on line 420 in play", blueCount, 4);
		checkValue("red clocks on line 420 in play", redCount, 0);

		// Bullet from the last row has long expired at top 10
		writeExpect(spaceInvPkg::REG_CTRL, 32'h0, 1'b0, "CTRL clear");
		checkStatus(1'b0, 1'b0, 10, 100, "after enable cleared");
		scanLine(10'd420, greenCount, blueCount, redCount);
		checkValue("green clocks on line 420 in title", greenCount, 0);
		checkValue("blue clocks on line 420 in title", blueCount, 4);
		checkValue("red clocks on line 420 in title", redCount, 0);

		measureVsync();

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* vgaTiming.sv */
// 640x480 VGA timing with half-rate pixel enable, counters, syncs and blanking
`timescale 1ns/1ps

module vgaTiming (
	input  logic               clk,
	input  logic               reset,
	output logic               pixEn,
	output logic               hsync,
	output logic               vsync,
	output logic               blankB,
	output spaceInvPkg::coordT hCount,
	output spaceInvPkg::coordT vCount
);

	logic lineEnd;

	assign lineEnd = (hCount == spaceInvPkg::H_TOTAL - 10'd1);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pixEn  <= 1'b0;
			hCount <= '0;
			vCount <= '0;
			hsync  <= 1'b1;
			vsync  <= 1'b1;
			blankB <= 1'b0;
		end
		else
		begin
			pixEn <= ~pixEn;
			if (pixEn)
			begin
				hCount <= lineEnd ? 10'd0 : hCount + 10'd1;
				if (lineEnd)
					vCount <= (vCount == spaceInvPkg::V_TOTAL - 10'd1) ? 10'd0 : vCount + 10'd1;
				// Registered so syncs line up with the mixer colours
				hsync <= ~((hCount >= spaceInvPkg::H_ACTIVE + spaceInvPkg::H_FP) &&
					(hCount < spaceInvPkg::H_ACTIVE + spaceInvPkg::H_FP + spaceInvPkg::H_SYNC));
				vsync <= ~((vCount >= spaceInvPkg::V_ACTIVE + spaceInvPkg::V_FP) &&
					(vCount < spaceInvPkg::V_ACTIVE + spaceInvPkg::V_FP + spaceInvPkg::V_SYNC));
				blankB <= (hCount < spaceInvPkg::H_ACTIVE) && (vCount < spaceInvPkg::V_ACTIVE);
			end
		end
	end

endmodule
